// File: mips_arch_pkg.sv
// data word is fixed at 32 bits; HI and LO each carry one full word even when WIDTH is narrower
package mips_arch_pkg;

        // one architectural data word
        typedef logic [31:0] word_t;

        // hi is the remainder, lo the quotient
        typedef struct packed {
                word_t hi;
                word_t lo;
        } hilo_t;

        // divider sequence
        typedef enum logic [1:0] {
                div_free    = 2'b00,
                div_by_zero = 2'b01,
                div_on      = 2'b10,
                div_finish  = 2'b11
        } div_state_e;

endpackage

// File: axil_pkg.sv
// AXI4-Lite with 8-bit byte addresses and 32-bit data; wstrb is carried but every register is written whole
package axil_pkg;

        typedef logic [7:0] axil_addr_t;

        // everything the master drives
        typedef struct packed {
                logic        awvalid;
                axil_addr_t  awaddr;
                logic        wvalid;
                logic [31:0] wdata;
                logic [3:0]  wstrb;
                logic        bready;
                logic        arvalid;
                axil_addr_t  araddr;
                logic        rready;
        } axil_req_t;

        // everything the slave drives
        typedef struct packed {
                logic        awready;
                logic        wready;
                logic        bvalid;
                logic [1:0]  bresp;
                logic        arready;
                logic        rvalid;
                logic [31:0] rdata;
                logic [1:0]  rresp;
        } axil_rsp_t;

        localparam logic [1:0] resp_okay   = 2'd0;
        localparam logic [1:0] resp_slverr = 2'd2;

        // register map, byte offsets
        localparam axil_addr_t reg_op1      = 8'h00;
        localparam axil_addr_t reg_op2      = 8'h04;
        localparam axil_addr_t reg_div_ctrl = 8'h08;
        localparam axil_addr_t reg_hi       = 8'h0C;
        localparam axil_addr_t reg_lo       = 8'h10;
        localparam axil_addr_t reg_count    = 8'h14;
        localparam axil_addr_t reg_compare  = 8'h18;

endpackage

// File: div_ctrl.sv
// WIDTH from 8 to 32; a start outside the free state is ignored, done_o pulses once per division
`timescale 1ns/1ns

module div_ctrl #(
        parameter int WIDTH = 32
) (
        input  logic clk,
        input  logic rst_n_i,
        input  logic start_i,
        input  logic divisor_zero_i,
        output logic load_o,
        output logic step_o,
        output logic finish_o,
        output logic clear_o,
        output logic busy_o,
        output logic done_o
);
        import mips_arch_pkg::*;

        localparam int CNT_W = $clog2(WIDTH);

        div_state_e       state_q;
        div_state_e       state_d;
        logic [CNT_W-1:0] cnt_q;

        always_comb
        begin
                state_d = state_q;
                case (state_q)
                        div_free:
                                if (start_i)
                                        state_d = div_by_zero;
                        div_by_zero:
                                if (divisor_zero_i)
                                        state_d = div_finish;
                                else
                                        state_d = div_on;
                        div_on:
                                if (cnt_q == CNT_W'(WIDTH - 1))
                                        state_d = div_finish;
                        default:
                                state_d = div_free;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                begin
                        state_q <= div_free;
                        cnt_q   <= '0;
                end
                else
                begin
                        state_q <= state_d;
                        // one count per shift-subtract step
                        if (state_q == div_on)
                                cnt_q <= cnt_q + 1'b1;
                        else
                                cnt_q <= '0;
                end
        end

        assign load_o   = (state_q == div_free) && start_i;
        assign clear_o  = (state_q == div_by_zero) && divisor_zero_i;
        assign step_o   = (state_q == div_on);
        assign finish_o = (state_q == div_finish);
        assign done_o   = (state_q == div_finish);
        assign busy_o   = (state_q != div_free);

endmodule

// File: div_datapath.sv
// WIDTH from 8 to 32 uses the low WIDTH bits of each operand; results are extended to a full word
`timescale 1ns/1ns

module div_datapath #(
        parameter int WIDTH = 32
) (
        input  logic                 clk,
        input  logic                 rst_n_i,
        input  logic                 load_i,
        input  logic                 step_i,
        input  logic                 finish_i,
        input  logic                 clear_i,
        input  logic                 signed_i,
        input  mips_arch_pkg::word_t op1_i,
        input  mips_arch_pkg::word_t op2_i,
        output logic                 divisor_zero_o,
        output mips_arch_pkg::hilo_t result_o
);
        import mips_arch_pkg::*;

        logic [WIDTH-1:0]   dividend;
        logic [WIDTH-1:0]   divisor;
        logic               dividend_neg;
        logic               divisor_neg;
        logic [WIDTH-1:0]   dividend_mag;
        logic [WIDTH-1:0]   divisor_mag;
        logic [WIDTH-1:0]   dvs_q;
        logic [2*WIDTH-1:0] rq_q;
        logic [WIDTH:0]     trial;
        logic               sgn_q;
        logic               neg_quo_q;
        logic               neg_rem_q;
        logic [WIDTH-1:0]   quo_fix;
        logic [WIDTH-1:0]   rem_fix;

        assign dividend     = op1_i[WIDTH-1:0];
        assign divisor      = op2_i[WIDTH-1:0];
        assign dividend_neg = signed_i & dividend[WIDTH-1];
        assign divisor_neg  = signed_i & divisor[WIDTH-1];
        assign dividend_mag = dividend_neg ? -dividend : dividend;
        assign divisor_mag  = divisor_neg ? -divisor : divisor;

        assign divisor_zero_o = (dvs_q == '0);

        // shifted partial remainder minus divisor, msb is the borrow
        assign trial = rq_q[2*WIDTH-1:WIDTH-1] - {1'b0, dvs_q};

        // upper half remainder, lower half quotient
        always_ff @(posedge clk)
        begin
                if (load_i)
                begin
                        dvs_q <= divisor_mag;
                        rq_q  <= {{WIDTH{1'b0}}, dividend_mag};
                end
                else if (clear_i)
                        rq_q <= '0;
                else if (step_i)
                begin
                        if (trial[WIDTH])
                                rq_q <= {rq_q[2*WIDTH-2:0], 1'b0};
                        else
                                rq_q <= {trial[WIDTH-1:0], rq_q[WIDTH-2:0], 1'b1};
                end
        end

        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                begin
                        sgn_q     <= 1'b0;
                        neg_quo_q <= 1'b0;
                        neg_rem_q <= 1'b0;
                end
                else if (load_i)
                begin
                        sgn_q     <= signed_i;
                        neg_quo_q <= dividend_neg ^ divisor_neg;
                        neg_rem_q <= dividend_neg;
                end
        end

        // quotient truncates toward zero, remainder follows the dividend
        assign quo_fix = neg_quo_q ? -rq_q[WIDTH-1:0] : rq_q[WIDTH-1:0];
        assign rem_fix = neg_rem_q ? -rq_q[2*WIDTH-1:WIDTH] : rq_q[2*WIDTH-1:WIDTH];

        // result only presented during the finish cycle
        always_comb
        begin
                result_o = '0;
                if (finish_i)
                begin
                        if (sgn_q)
                        begin
                                result_o.hi = word_t'($signed(rem_fix));
                                result_o.lo = word_t'($signed(quo_fix));
                        end
                        else
                        begin
                                result_o.hi = word_t'(rem_fix);
                                result_o.lo = word_t'(quo_fix);
                        end
                end
        end

endmodule

// File: cp0_timer.sv
// TICK_DIV of 1 or more; a Compare of zero never raises the interrupt
`timescale 1ns/1ns

module cp0_timer #(
        parameter int TICK_DIV = 2
) (
        input  logic                 clk,
        input  logic                 rst_n_i,
        input  logic                 count_we_i,
        input  logic                 compare_we_i,
        input  mips_arch_pkg::word_t wdata_i,
        output mips_arch_pkg::word_t count_o,
        output mips_arch_pkg::word_t compare_o,
        output logic                 timer_int_o
);
        localparam int PRE_W = $clog2(TICK_DIV + 1);

        logic [PRE_W-1:0] pre_q;
        logic             tick;

        assign tick = (pre_q == PRE_W'(TICK_DIV - 1));

        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                begin
                        pre_q       <= '0;
                        count_o     <= '0;
                        compare_o   <= '0;
                        timer_int_o <= 1'b0;
                end
                else
                begin
                        // a Count write restarts the prescaler
                        if (count_we_i || tick)
                                pre_q <= '0;
                        else
                                pre_q <= pre_q + 1'b1;

                        if (count_we_i)
                                count_o <= wdata_i;
                        else if (tick)
                                count_o <= count_o + 1'b1;

                        if (compare_we_i)
                                compare_o <= wdata_i;

                        // sticky until Compare is rewritten
                        if (compare_we_i)
                                timer_int_o <= 1'b0;
                        else if ((compare_o != '0) && (count_o == compare_o))
                                timer_int_o <= 1'b1;
                end
        end

endmodule

// File: axil_regs.sv
// one outstanding write and one outstanding read; HI and LO are read only, unknown offsets answer SLVERR
`timescale 1ns/1ns

module axil_regs (
        input  logic                 clk,
        input  logic                 rst_n_i,
        input  axil_pkg::axil_req_t  axil_req_i,
        input  logic                 busy_i,
        input  logic                 done_i,
        input  mips_arch_pkg::hilo_t result_i,
        input  mips_arch_pkg::word_t count_i,
        input  mips_arch_pkg::word_t compare_i,
        output axil_pkg::axil_rsp_t  axil_rsp_o,
        output logic                 start_o,
        output logic                 signed_o,
        output logic                 count_we_o,
        output logic                 compare_we_o,
        output mips_arch_pkg::word_t op1_o,
        output mips_arch_pkg::word_t op2_o,
        output mips_arch_pkg::word_t wdata_o
);
        import axil_pkg::*;
        import mips_arch_pkg::*;

        logic       wr_en;
        logic       rd_en;
        logic       op1_we;
        logic       op2_we;
        logic       wr_err;
        logic       rd_err;
        word_t      rd_data;
        logic       bvalid_q;
        logic       rvalid_q;
        logic [1:0] bresp_q;
        logic [1:0] rresp_q;
        word_t      rdata_q;
        hilo_t      hilo_q;

        // address and data accepted together
        assign wr_en = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
        assign rd_en = axil_req_i.arvalid & ~rvalid_q;

        assign wdata_o  = axil_req_i.wdata;
        assign signed_o = axil_req_i.wdata[1];

        always_comb
        begin
                op1_we       = 1'b0;
                op2_we       = 1'b0;
                start_o      = 1'b0;
                count_we_o   = 1'b0;
                compare_we_o = 1'b0;
                wr_err       = 1'b0;
                case (axil_req_i.awaddr)
                        reg_op1:      op1_we = wr_en;
                        reg_op2:      op2_we = wr_en;
                        reg_div_ctrl: start_o = wr_en & axil_req_i.wdata[0] & ~busy_i;
                        reg_count:    count_we_o = wr_en;
                        reg_compare:  compare_we_o = wr_en;
                        default:      wr_err = 1'b1;
                endcase
        end

        always_comb
        begin
                rd_data = '0;
                rd_err  = 1'b0;
                case (axil_req_i.araddr)
                        reg_op1:      rd_data = op1_o;
                        reg_op2:      rd_data = op2_o;
                        reg_div_ctrl: rd_data = {31'b0, busy_i};
                        reg_hi:       rd_data = hilo_q.hi;
                        reg_lo:       rd_data = hilo_q.lo;
                        reg_count:    rd_data = count_i;
                        reg_compare:  rd_data = compare_i;
                        default:      rd_err = 1'b1;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (op1_we)
                        op1_o <= axil_req_i.wdata;
                if (op2_we)
                        op2_o <= axil_req_i.wdata;
                if (wr_en)
                        bresp_q <= wr_err ? resp_slverr : resp_okay;
                if (rd_en)
                begin
                        rdata_q <= rd_data;
                        rresp_q <= rd_err ? resp_slverr : resp_okay;
                end
        end

        always_ff @(posedge clk)
        begin
                if (!rst_n_i)
                begin
                        bvalid_q <= 1'b0;
                        rvalid_q <= 1'b0;
                        hilo_q   <= '0;
                end
                else
                begin
                        if (wr_en)
                                bvalid_q <= 1'b1;
                        else if (axil_req_i.bready)
                                bvalid_q <= 1'b0;

                        if (rd_en)
                                rvalid_q <= 1'b1;
                        else if (axil_req_i.rready)
                                rvalid_q <= 1'b0;

                        if (done_i)
                                hilo_q <= result_i;
                end
        end

        assign axil_rsp_o.awready = wr_en;
        assign axil_rsp_o.wready  = wr_en;
        assign axil_rsp_o.bvalid  = bvalid_q;
        assign axil_rsp_o.bresp   = bresp_q;
        assign axil_rsp_o.arready = ~rvalid_q;
        assign axil_rsp_o.rvalid  = rvalid_q;
        assign axil_rsp_o.rdata   = rdata_q;
        assign axil_rsp_o.rresp   = rresp_q;

endmodule

// File: div_timer_unit.sv
// WIDTH from 8 to 32 and even, TICK_DIV of 1 or more; host access is AXI4-Lite only
`timescale 1ns/1ns

module div_timer_unit #(
        parameter int WIDTH    = 32,
        parameter int TICK_DIV = 2
) (
        input  logic                clk,
        input  logic                rst_n_i,
        input  axil_pkg::axil_req_t axil_req_i,
        output axil_pkg::axil_rsp_t axil_rsp_o,
        output logic                timer_int_o
);
        import mips_arch_pkg::*;

        logic  start;
        logic  signed_div;
        logic  load;
        logic  step;
        logic  finish;
        logic  clear;
        logic  busy;
        logic  done;
        logic  divisor_zero;
        logic  count_we;
        logic  compare_we;
        word_t op1;
        word_t op2;
        word_t wdata;
        word_t count;
        word_t compare;
        hilo_t result;

        axil_regs i_axil_regs (
                .clk          (clk),
                .rst_n_i      (rst_n_i),
                .axil_req_i   (axil_req_i),
                .busy_i       (busy),
                .done_i       (done),
                .result_i     (result),
                .count_i      (count),
                .compare_i    (compare),
                .axil_rsp_o   (axil_rsp_o),
                .start_o      (start),
                .signed_o     (signed_div),
                .count_we_o   (count_we),
                .compare_we_o (compare_we),
                .op1_o        (op1),
                .op2_o        (op2),
                .wdata_o      (wdata)
        );

        div_ctrl #(
                .WIDTH (WIDTH)
        ) i_div_ctrl (
                .clk            (clk),
                .rst_n_i        (rst_n_i),
                .start_i        (start),
                .divisor_zero_i (divisor_zero),
                .load_o         (load),
                .step_o         (step),
                .finish_o       (finish),
                .clear_o        (clear),
                .busy_o         (busy),
                .done_o         (done)
        );

        div_datapath #(
                .WIDTH (WIDTH)
        ) i_div_datapath (
                .clk            (clk),
                .rst_n_i        (rst_n_i),
                .load_i         (load),
                .step_i         (step),
                .finish_i       (finish),
                .clear_i        (clear),
                .signed_i       (signed_div),
                .op1_i          (op1),
                .op2_i          (op2),
                .divisor_zero_o (divisor_zero),
                .result_o       (result)
        );

        cp0_timer #(
                .TICK_DIV (TICK_DIV)
        ) i_cp0_timer (
                .clk          (clk),
                .rst_n_i      (rst_n_i),
                .count_we_i   (count_we),
                .compare_we_i (compare_we),
                .wdata_i      (wdata),
                .count_o      (count),
                .compare_o    (compare),
                .timer_int_o  (timer_int_o)
        );

endmodule

// File: tb_axil_tasks.svh
// bus tasks for the testbench top; bready and rready stay high and only one transaction runs at a time
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

localparam int bus_timeout = 50;

// address and data offered together, held until the write response shows
task automatic axil_write(input axil_addr_t addr, input word_t data, output logic [1:0] resp);
        int n;
        @(negedge clk);
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hF;
        req.bready  = 1'b1;
        n = 0;
        // slave is idle, so address and data go on the first edge
        @(posedge clk);
        check_val("awready", rsp.awready, 32'd1);
        check_val("wready", rsp.wready, 32'd1);
        @(negedge clk);
        while (!rsp.bvalid && n < bus_timeout)
        begin
                @(negedge clk);
                n++;
        end
        resp = rsp.bresp;
        if (!rsp.bvalid)
        begin
                $display("write to offset %h got no response within %0d cycles", addr, bus_timeout);
                errors++;
                resp = resp_slverr;
        end
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
endtask

task automatic axil_read(input axil_addr_t addr, output word_t data, output logic [1:0] resp);
        int n;
        @(negedge clk);
        req.arvalid = 1'b1;
        req.araddr  = addr;
        req.rready  = 1'b1;
        n = 0;
        @(posedge clk);
        check_val("arready", rsp.arready, 32'd1);
        @(negedge clk);
        while (!rsp.rvalid && n < bus_timeout)
        begin
                @(negedge clk);
                n++;
        end
        data = rsp.rdata;
        resp = rsp.rresp;
        if (!rsp.rvalid)
        begin
                $display("read of offset %h got no data within %0d cycles", addr, bus_timeout);
                errors++;
                data = '0;
                resp = resp_slverr;
        end
        req.arvalid = 1'b0;
endtask

`endif

// File: tb_div_timer.sv
// runs with WIDTH 32 and TICK_DIV 2; every wait gives up after a bounded number of cycles
`timescale 1ns/1ns

module tb_div_timer;
        import axil_pkg::*;
        import mips_arch_pkg::*;

        logic        clk;
        logic        rst_n;
        axil_req_t   req;
        axil_rsp_t   rsp;
        logic        timer_int;
        logic [31:0] lfsr;
        int          errors;
        int          checks;
        int          tests;
        int          err_mark;

        div_timer_unit #(
                .WIDTH    (32),
                .TICK_DIV (2)
        ) i_dut (
                .clk         (clk),
                .rst_n_i     (rst_n),
                .axil_req_i  (req),
                .axil_rsp_o  (rsp),
                .timer_int_o (timer_int)
        );

        initial
        begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        `include "tb_axil_tasks.svh"

        function automatic logic [31:0] galois_step(input logic [31:0] s);
                if (s[0])
                        return (s >> 1) ^ 32'h8020_0003;
                return s >> 1;
        endfunction

        // one lfsr step per bit taken
        task automatic draw_bits(input int n, output word_t w);
                int i;
                w = '0;
                for (i = 0; i < n; i++)
                begin
                        w    = {w[30:0], lfsr[0]};
                        lfsr = galois_step(lfsr);
                end
        endtask

        // truncating division, remainder keeps the dividend sign, zero divisor gives zeros
        function automatic hilo_t ref_div(input word_t a, input word_t b, input logic sgn);
                longint na;
                longint nb;
                hilo_t  r;
                if (b == '0)
                        return '0;
                na = sgn ? longint'($signed(a)) : longint'({32'b0, a});
                nb = sgn ? longint'($signed(b)) : longint'({32'b0, b});
                r.lo = word_t'(na / nb);
                r.hi = word_t'(na % nb);
                return r;
        endfunction

        task automatic check_val(input string name, input word_t got, input word_t exp);
                checks++;
                if (got !== exp)
                begin
                        $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
                        errors++;
                end
        endtask

        task automatic end_test(input string name);
                tests++;
                $display("test %s finished with %0d errors", name, errors - err_mark);
                err_mark = errors;
        endtask

        task automatic run_div(input word_t a, input word_t b, input logic sgn);
                word_t      ctrl;
                word_t      hi;
                word_t      lo;
                logic [1:0] resp;
                hilo_t      exp;
                int         n;
                axil_write(reg_op1, a, resp);
                axil_write(reg_op2, b, resp);
                axil_write(reg_div_ctrl, {30'b0, sgn, 1'b1}, resp);
                ctrl = 32'd1;
                n = 0;
                while (ctrl[0] && n < 100)
                begin
                        axil_read(reg_div_ctrl, ctrl, resp);
                        n++;
                end
                if (ctrl[0])
                begin
                        $display("divider still busy after 100 polls at %0t", $time);
                        errors++;
                end
                axil_read(reg_hi, hi, resp);
                axil_read(reg_lo, lo, resp);
                exp = ref_div(a, b, sgn);
                check_val("reg_hi", hi, exp.hi);
                check_val("reg_lo", lo, exp.lo);
        endtask

        initial
        begin
                word_t      a;
                word_t      b;
                word_t      d;
                word_t      sh;
                word_t      c1;
                word_t      c2;
                logic [1:0] resp;
                logic       stay;
                int         n;
                req      = '0;
                rst_n    = 1'b0;
                lfsr     = 32'd89634;
                errors   = 0;
                checks   = 0;
                tests    = 0;
                err_mark = 0;
                repeat (3) @(negedge clk);
                rst_n = 1'b1;

                axil_read(reg_hi, d, resp);
                check_val("reg_hi", d, 32'd0);
                axil_read(reg_lo, d, resp);
                check_val("reg_lo", d, 32'd0);
                axil_read(reg_compare, d, resp);
                check_val("reg_compare", d, 32'd0);
                check_val("timer_int_o", timer_int, 32'd0);
                end_test("reset values");

                // shifted divisors give quotients of many sizes
                repeat (20)
                begin
                        draw_bits(32, a);
                        draw_bits(32, b);
                        draw_bits(5, sh);
                        run_div(a, b >> sh, 1'b0);
                end
                end_test("unsigned divide");

                repeat (10)
                begin
                        draw_bits(32, a);
                        draw_bits(32, b);
                        draw_bits(5, sh);
                        run_div(a, word_t'($signed(b) >>> sh), 1'b1);
                end
                run_div(32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
                run_div(32'h8000_0000, 32'd7, 1'b1);
                run_div(-32'sd7, 32'd2, 1'b1);
                run_div(32'd7, -32'sd2, 1'b1);
                run_div(-32'sd7, -32'sd2, 1'b1);
                end_test("signed divide");

                run_div(32'd123, 32'd0, 1'b0);
                run_div(-32'sd5, 32'd0, 1'b1);
                end_test("divide by zero");

                axil_write(reg_count, 32'd0, resp);
                axil_write(reg_compare, 32'd40, resp);
                n = 0;
                while (!timer_int && n < 200)
                begin
                        @(negedge clk);
                        n++;
                end
                if (!timer_int)
                begin
                        $display("timer interrupt did not rise within 200 cycles");
                        errors++;
                end
                stay = 1'b1;
                repeat (10)
                begin
                        @(negedge clk);
                        stay = stay & timer_int;
                end
                check_val("timer_int_o held", stay, 32'd1);
                axil_write(reg_compare, 32'd0, resp);
                check_val("timer_int_o", timer_int, 32'd0);
                axil_read(reg_count, c1, resp);
                axil_read(reg_count, c2, resp);
                check_val("count increasing", c2 > c1, 32'd1);
                end_test("timer");

                axil_read(8'h1C, d, resp);
                check_val("rresp", resp, resp_slverr);
                check_val("rdata", d, 32'd0);
                axil_read(reg_lo, c1, resp);
                axil_write(reg_lo, 32'h1234_5678, resp);
                check_val("bresp", resp, resp_slverr);
                axil_read(reg_lo, d, resp);
                check_val("reg_lo", d, c1);
                end_test("bus errors");

                $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
                if (errors == 0)
                        $display("TESTS PASSED");
                else
                        $display("TESTS FAILED");
                $finish;
        end

endmodule

// File: verilog.f
+incdir+.
mips_arch_pkg.sv
axil_pkg.sv
div_ctrl.sv
div_datapath.sv
cp0_timer.sv
axil_regs.sv
div_timer_unit.sv
tb_div_timer.sv
